/* hw/chip8_pkg.sv */
// CHIP-8 host register definitions
`default_nettype none

package chip8_pkg;

    localparam int HOST_ADDR_W = 18;
    localparam int HOST_DATA_W = 32;

    // Host register map
    localparam logic [HOST_ADDR_W-1:0] ADDR_V_BASE = 18'h00;
    localparam logic [HOST_ADDR_W-1:0] ADDR_I      = 18'h10;
    localparam logic [HOST_ADDR_W-1:0] ADDR_SOUND  = 18'h11;
    localparam logic [HOST_ADDR_W-1:0] ADDR_DELAY  = 18'h12;
    localparam logic [HOST_ADDR_W-1:0] ADDR_PC     = 18'h14;
    localparam logic [HOST_ADDR_W-1:0] ADDR_KEY    = 18'h15;
    localparam logic [HOST_ADDR_W-1:0] ADDR_STATE  = 18'h16;
    localparam logic [HOST_ADDR_W-1:0] ADDR_FB     = 18'h17;
    localparam logic [HOST_ADDR_W-1:0] ADDR_MEM    = 18'h19;

    localparam logic [HOST_DATA_W-1:0] UNMAPPED_VALUE = 32'h65;
    localparam logic [11:0]            PC_RESET       = 12'h200;

    typedef struct packed {
        logic                   write;
        logic [HOST_ADDR_W-1:0] addr;
        logic [HOST_DATA_W-1:0] data;
    } host_req_t;

    typedef struct packed {
        logic                   is_read;
        logic [HOST_DATA_W-1:0] data;
    } host_rsp_t;

    typedef struct packed {
        logic [18:0] pad;
        logic        we;
        logic        pix;
        logic [5:0]  x;
        logic [4:0]  y;
    } fb_cmd_t;

    typedef struct packed {
        logic [10:0] pad;
        logic        we;
        logic [11:0] addr;
        logic [7:0]  data;
    } mem_cmd_t;

    // Same data word, decoded by target address
    typedef union packed {
        fb_cmd_t  fb;
        mem_cmd_t mem;
    } host_word_u;

    typedef enum logic [1:0] {
        RUNNING      = 2'd0,
        LOADING_ROM  = 2'd1,
        LOADING_FONT = 2'd2,
        PAUSED       = 2'd3
    } emu_state_e;

endpackage

`default_nettype wire

/* hw/axil_host_port.sv */
// AXI4-Lite host port
`timescale 1ns/1ns
`default_nettype none

module axil_host_port import chip8_pkg::*; (
    input  logic                   clk,
    input  logic                   cpu_fbreset,
    input  logic [HOST_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [HOST_DATA_W-1:0] wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [HOST_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [HOST_DATA_W-1:0] rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    output host_req_t              req,
    output logic                   req_push,
    input  logic                   req_full,
    input  host_rsp_t              rsp,
    input  logic                   rsp_empty,
    output logic                   rsp_pop
);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic can_take;
    logic wr_go;
    logic rd_go;

    // A push still in flight has not reached the full flag yet
    assign can_take = !req_full && !req_push;

    // Write wins when both channels are pending
    assign wr_go = awvalid && wvalid && can_take;
    assign rd_go = arvalid && !(awvalid && wvalid) && can_take;

    assign awready = wr_go;
    assign wready  = wr_go;
    assign arready = rd_go;

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            req_push <= 1'b0;
        end else begin
            req_push <= wr_go || rd_go;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            req.write <= 1'b1;
            req.addr  <= awaddr;
            req.data  <= wdata;
        end else if (rd_go) begin
            req.write <= 1'b0;
            req.addr  <= araddr;
            req.data  <= '0;
        end
    end

    // Next response only once B and R are both idle
    assign rsp_pop = !rsp_empty && !bvalid && !rvalid;

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (rsp_pop) begin
                if (rsp.is_read) begin
                    rvalid <= 1'b1;
                end else begin
                    bvalid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_pop) begin
            rdata <= rsp.data;
        end
    end

    assign bresp = RESP_OKAY;
    assign rresp = RESP_OKAY;

endmodule

`default_nettype wire

/* hw/host_fifo.sv */
// Synchronous queue
`timescale 1ns/1ns
`default_nettype none

module host_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             cpu_fbreset,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    output logic             full,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] slots [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign pop_data = slots[rd_ptr];

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            slots[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

/* hw/chip8_reg_block.sv */
// CHIP-8 host register block
`timescale 1ns/1ns
`default_nettype none

module chip8_reg_block import chip8_pkg::*; (
    input  logic       clk,
    input  logic       cpu_fbreset,
    input  host_req_t  req,
    input  logic       req_empty,
    output logic       req_pop,
    output host_rsp_t  rsp,
    input  logic       rsp_full,
    output logic       rsp_push,
    output logic       delay_load,
    output logic       sound_load,
    output logic [7:0] timer_value,
    input  logic [7:0] delay_count,
    input  logic [7:0] sound_count
);

    logic [7:0]  v_regs [16];
    logic [15:0] i_reg;
    logic [11:0] pc;
    logic        key_pressed;
    logic [3:0]  key_code;
    emu_state_e  state;

    // 64x32 display, one bit per pixel, indexed {y, x}
    logic        fb_mem [2048];
    logic        fb_q;
    logic [5:0]  fb_x_prev;
    logic [4:0]  fb_y_prev;

    logic [7:0]  prog_mem [4096];
    logic [7:0]  mem_q;
    logic [11:0] mem_addr_prev;

    // Access in execute stage
    logic        ex_valid;
    host_req_t   ex_req;
    host_word_u  cmd;
    logic        v_hit;
    logic        wr_en;

    logic [HOST_DATA_W-1:0] rd_next;
    logic [HOST_DATA_W-1:0] rd_word;
    logic                   rd_fb;
    logic                   rd_mem;
    logic                   rsp_is_read;

    assign req_pop = !req_empty && !rsp_full && !ex_valid && !rsp_push;

    assign cmd   = ex_req.data;
    assign v_hit = ex_req.addr[HOST_ADDR_W-1:4] == ADDR_V_BASE[HOST_ADDR_W-1:4];
    assign wr_en = ex_valid && ex_req.write;

    always_comb begin
        rd_next = UNMAPPED_VALUE;
        if (v_hit) begin
            rd_next = {24'h0, v_regs[ex_req.addr[3:0]]};
        end else begin
            case (ex_req.addr)
                ADDR_I:     rd_next = {16'h0, i_reg};
                ADDR_SOUND: rd_next = {24'h0, sound_count};
                ADDR_DELAY: rd_next = {24'h0, delay_count};
                ADDR_PC:    rd_next = {20'h0, pc};
                ADDR_KEY:   rd_next = {27'h0, key_pressed, key_code};
                ADDR_STATE: rd_next = {30'h0, state};
                default:    rd_next = UNMAPPED_VALUE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            ex_valid      <= 1'b0;
            rsp_push      <= 1'b0;
            delay_load    <= 1'b0;
            sound_load    <= 1'b0;
            i_reg         <= 16'h0;
            pc            <= PC_RESET;
            key_pressed   <= 1'b0;
            key_code      <= 4'h0;
            state         <= PAUSED;
            fb_x_prev     <= 6'h0;
            fb_y_prev     <= 5'h0;
            mem_addr_prev <= 12'h0;
        end else begin
            ex_valid   <= req_pop;
            rsp_push   <= ex_valid;
            delay_load <= wr_en && (ex_req.addr == ADDR_DELAY);
            sound_load <= wr_en && (ex_req.addr == ADDR_SOUND);
            if (wr_en) begin
                case (ex_req.addr)
                    ADDR_I:     i_reg <= ex_req.data[15:0];
                    ADDR_PC:    pc <= ex_req.data[11:0];
                    ADDR_KEY:   {key_pressed, key_code} <= ex_req.data[4:0];
                    ADDR_STATE: state <= emu_state_e'(ex_req.data[1:0]);
                    ADDR_FB: begin
                        fb_x_prev <= cmd.fb.x;
                        fb_y_prev <= cmd.fb.y;
                    end
                    ADDR_MEM:   mem_addr_prev <= cmd.mem.addr;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_pop) begin
            ex_req <= req;
        end
        if (ex_valid) begin
            rd_word     <= rd_next;
            rd_fb       <= (ex_req.addr == ADDR_FB);
            rd_mem      <= (ex_req.addr == ADDR_MEM);
            rsp_is_read <= !ex_req.write;
            timer_value <= ex_req.data[7:0];
        end
        if (wr_en && v_hit) begin
            v_regs[ex_req.addr[3:0]] <= ex_req.data[7:0];
        end
        if (wr_en && ex_req.addr == ADDR_FB && cmd.fb.we) begin
            fb_mem[{cmd.fb.y, cmd.fb.x}] <= cmd.fb.pix;
        end
        if (wr_en && ex_req.addr == ADDR_MEM && cmd.mem.we) begin
            prog_mem[cmd.mem.addr] <= cmd.mem.data;
        end
        // Synchronous reads at the last written location
        fb_q  <= fb_mem[{fb_y_prev, fb_x_prev}];
        mem_q <= prog_mem[mem_addr_prev];
    end

    always_comb begin
        rsp.is_read = rsp_is_read;
        if (rd_fb) begin
            rsp.data = {31'h0, fb_q};
        end else if (rd_mem) begin
            rsp.data = {12'h0, mem_addr_prev, mem_q};
        end else begin
            rsp.data = rd_word;
        end
    end

endmodule

`default_nettype wire

/* hw/chip8_timers.sv */
// CHIP-8 delay and sound timers
`timescale 1ns/1ns
`default_nettype none

module chip8_timers #(
    parameter int TICK_DIV = 833333
) (
    input  logic       clk,
    input  logic       cpu_fbreset,
    input  logic       delay_load,
    input  logic       sound_load,
    input  logic [7:0] timer_value,
    output logic [7:0] delay_count,
    output logic [7:0] sound_count
);

    localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             tick;

    // 60 Hz tick on hardware
    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (div_cnt == DIV_W'(TICK_DIV - 1)) begin
            div_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_fbreset) begin
            delay_count <= 8'h0;
            sound_count <= 8'h0;
        end else begin
            if (delay_load) begin
                delay_count <= timer_value;
            end else if (tick && delay_count != 8'h0) begin
                delay_count <= delay_count - 1'b1;
            end
            if (sound_load) begin
                sound_count <= timer_value;
            end else if (tick && sound_count != 8'h0) begin
                sound_count <= sound_count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/chip8_host_top.sv */
// CHIP-8 host register top level
`timescale 1ns/1ns
`default_nettype none

module chip8_host_top import chip8_pkg::*; #(
    parameter int TICK_DIV   = 833333,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   cpu_fbreset,
    input  logic [HOST_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [HOST_DATA_W-1:0] wdata,
    input  logic [3:0]             wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [HOST_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [HOST_DATA_W-1:0] rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready
);

    host_req_t  port_req, blk_req;
    host_rsp_t  blk_rsp, port_rsp;
    logic       req_push, req_full, req_pop, req_empty;
    logic       rsp_push, rsp_full, rsp_pop, rsp_empty;
    logic       delay_load, sound_load;
    logic [7:0] timer_value, delay_count, sound_count;

    axil_host_port port (
        .clk(clk), .cpu_fbreset(cpu_fbreset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .req(port_req), .req_push(req_push), .req_full(req_full),
        .rsp(port_rsp), .rsp_empty(rsp_empty), .rsp_pop(rsp_pop)
    );

    host_fifo #(.WIDTH($bits(host_req_t)), .DEPTH(FIFO_DEPTH)) req_q (
        .clk(clk), .cpu_fbreset(cpu_fbreset),
        .push(req_push), .push_data(port_req), .full(req_full),
        .pop(req_pop), .pop_data(blk_req), .empty(req_empty)
    );

    host_fifo #(.WIDTH($bits(host_rsp_t)), .DEPTH(FIFO_DEPTH)) rsp_q (
        .clk(clk), .cpu_fbreset(cpu_fbreset),
        .push(rsp_push), .push_data(blk_rsp), .full(rsp_full),
        .pop(rsp_pop), .pop_data(port_rsp), .empty(rsp_empty)
    );

    chip8_reg_block regs (
        .clk(clk), .cpu_fbreset(cpu_fbreset),
        .req(blk_req), .req_empty(req_empty), .req_pop(req_pop),
        .rsp(blk_rsp), .rsp_full(rsp_full), .rsp_push(rsp_push),
        .delay_load(delay_load), .sound_load(sound_load), .timer_value(timer_value),
        .delay_count(delay_count), .sound_count(sound_count)
    );

    chip8_timers #(.TICK_DIV(TICK_DIV)) timers (
        .clk(clk), .cpu_fbreset(cpu_fbreset),
        .delay_load(delay_load), .sound_load(sound_load), .timer_value(timer_value),
        .delay_count(delay_count), .sound_count(sound_count)
    );

endmodule

`default_nettype wire

/* verif/tb_chip8_host.sv */
// CHIP-8 host register testbench
`timescale 1ns/1ns
`default_nettype none

module tb_chip8_host import chip8_pkg::*; ();

    localparam int TICK_DIV    = 8;
    localparam int HS_LIMIT    = 40;
    localparam int MAX_ENTRIES = 128;

    localparam logic [2:0] OP_WRITE   = 3'd0;
    localparam logic [2:0] OP_READ    = 3'd1;
    localparam logic [2:0] OP_RANGE   = 3'd2;
    localparam logic [2:0] OP_IDLE    = 3'd3;
    localparam logic [2:0] OP_ISSUE   = 3'd4;
    localparam logic [2:0] OP_COLLECT = 3'd5;

    localparam int SIG_AW = 0;
    localparam int SIG_B  = 1;
    localparam int SIG_AR = 2;
    localparam int SIG_R  = 3;

    typedef struct packed {
        logic [2:0]  op;
        logic [17:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic [15:0] wait_cycles;
    } test_entry_t;

    logic        clk;
    logic        cpu_fbreset;
    logic [17:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [17:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    test_entry_t tests [MAX_ENTRIES];
    logic [7:0]  v_vals [16];
    int          n_entries = 0;
    int          wait_sum = 0;
    int          error_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    integer      seed;

    chip8_host_top #(.TICK_DIV(TICK_DIV), .FIFO_DEPTH(4)) UUT (
        .clk(clk), .cpu_fbreset(cpu_fbreset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Run stopped at cycle %0d before all tests finished", cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] fb_word(input logic we, input logic pix,
                                            input logic [5:0] x, input logic [4:0] y);
        return {19'h0, we, pix, x, y};
    endfunction

    function automatic logic [31:0] mem_word(input logic we, input logic [11:0] addr,
                                             input logic [7:0] data);
        return {11'h0, we, addr, data};
    endfunction

    function automatic string op_name(input logic [2:0] op);
        case (op)
            OP_WRITE:   return "write";
            OP_READ:    return "read";
            OP_RANGE:   return "read range";
            OP_IDLE:    return "idle";
            OP_ISSUE:   return "issue";
            default:    return "collect";
        endcase
    endfunction

    task automatic add_entry(input logic [2:0] op, input logic [17:0] addr,
                             input logic [31:0] data, input logic [31:0] exp,
                             input int waits);
        tests[n_entries] = {op, addr, data, exp, 16'(waits)};
        n_entries = n_entries + 1;
        wait_sum = wait_sum + waits;
    endtask

    // Sampled at the falling edge, where every output is settled
    task automatic wait_for(input int which, input string name, output bit ok);
        int n;
        logic seen;
        n = 0;
        ok = 1'b0;
        while (!ok && n < HS_LIMIT) begin
            @(negedge clk);
            case (which)
                SIG_AW:  seen = awready;
                SIG_B:   seen = bvalid;
                SIG_AR:  seen = arready;
                default: seen = rvalid;
            endcase
            ok = (seen === 1'b1);
            n = n + 1;
        end
        if (!ok) begin
            $display("No %s from the DUT within %0d cycles", name, HS_LIMIT);
            error_count = error_count + 1;
        end
    endtask

    task automatic do_write(input logic [17:0] addr, input logic [31:0] data);
        bit ok;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        wait_for(SIG_AW, "awready", ok);
        if (ok && wready !== 1'b1) begin
            $display("mismatch wready: expected 0x1, got 0x%0h", wready);
            error_count = error_count + 1;
        end
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (ok) begin
            wait_for(SIG_B, "bvalid", ok);
            if (ok && bresp !== 2'b00) begin
                $display("mismatch bresp: expected 0x0, got 0x%0h", bresp);
                error_count = error_count + 1;
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic issue_read(input logic [17:0] addr);
        bit ok;
        araddr  = addr;
        arvalid = 1'b1;
        wait_for(SIG_AR, "arready", ok);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
    endtask

    task automatic collect_read(output logic [31:0] got, output bit ok);
        rready = 1'b1;
        wait_for(SIG_R, "rvalid", ok);
        got = rdata;
        if (ok && rresp !== 2'b00) begin
            $display("mismatch rresp: expected 0x0, got 0x%0h", rresp);
            error_count = error_count + 1;
        end
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic apply_entry(input test_entry_t t);
        logic [31:0] got;
        bit          ok;
        case (t.op)
            OP_WRITE: do_write(t.addr, t.data);
            OP_ISSUE: issue_read(t.addr);
            OP_IDLE: begin
                repeat (t.wait_cycles) @(posedge clk);
                #1;
            end
            default: begin
                if (t.op != OP_COLLECT) begin
                    issue_read(t.addr);
                end
                collect_read(got, ok);
                if (ok && t.op == OP_RANGE) begin
                    if ((^got === 1'bx) || got == 32'h0 || got > t.exp) begin
                        $display("mismatch rdata at 0x%0h: expected nonzero up to 0x%08h, got 0x%08h",
                                 t.addr, t.exp, got);
                        error_count = error_count + 1;
                    end
                end else if (ok && got !== t.exp) begin
                    $display("mismatch rdata at 0x%0h: expected 0x%08h, got 0x%08h",
                             t.addr, t.exp, got);
                    error_count = error_count + 1;
                end
            end
        endcase
    endtask

    task automatic build_tests();
        logic [31:0] val;
        // Reset values and unmapped addresses
        add_entry(OP_READ, ADDR_STATE, 0, 32'h3, 0);
        add_entry(OP_READ, ADDR_PC, 0, 32'h200, 0);
        add_entry(OP_READ, ADDR_I, 0, 32'h0, 0);
        add_entry(OP_READ, 18'h13, 0, 32'h65, 0);
        add_entry(OP_READ, 18'h18, 0, 32'h65, 0);
        add_entry(OP_READ, 18'h3F, 0, 32'h65, 0);
        for (int k = 0; k < 16; k++) begin
            val = $random(seed);
            v_vals[k] = val[7:0];
            add_entry(OP_WRITE, ADDR_V_BASE + 18'(k), val, 0, 0);
            add_entry(OP_READ, ADDR_V_BASE + 18'(k), 0, {24'h0, val[7:0]}, 0);
        end
        add_entry(OP_WRITE, ADDR_I, 32'hDEADBEEF, 0, 0);
        add_entry(OP_READ, ADDR_I, 0, 32'hBEEF, 0);
        add_entry(OP_WRITE, ADDR_PC, 32'h0000_5A7C, 0, 0);
        add_entry(OP_READ, ADDR_PC, 0, 32'hA7C, 0);
        add_entry(OP_WRITE, ADDR_KEY, 32'hFFFF_FFF7, 0, 0);
        add_entry(OP_READ, ADDR_KEY, 0, 32'h17, 0);
        for (int k = 0; k < 4; k++) begin
            add_entry(OP_WRITE, ADDR_STATE, 32'(k), 0, 0);
            add_entry(OP_READ, ADDR_STATE, 0, 32'(k), 0);
        end
        // Memory command word, second write has enable clear
        add_entry(OP_WRITE, ADDR_MEM, mem_word(1'b1, 12'h3A5, 8'h5C), 0, 0);
        add_entry(OP_READ, ADDR_MEM, 0, {12'h0, 12'h3A5, 8'h5C}, 0);
        add_entry(OP_WRITE, ADDR_MEM, mem_word(1'b0, 12'h3A5, 8'hC3), 0, 0);
        add_entry(OP_READ, ADDR_MEM, 0, {12'h0, 12'h3A5, 8'h5C}, 0);
        // Framebuffer, second pixel cleared first so it has a known value
        add_entry(OP_WRITE, ADDR_FB, fb_word(1'b1, 1'b1, 6'd37, 5'd19), 0, 0);
        add_entry(OP_READ, ADDR_FB, 0, 32'h1, 0);
        add_entry(OP_WRITE, ADDR_FB, fb_word(1'b1, 1'b0, 6'd5, 5'd30), 0, 0);
        add_entry(OP_WRITE, ADDR_FB, fb_word(1'b0, 1'b1, 6'd5, 5'd30), 0, 0);
        add_entry(OP_READ, ADDR_FB, 0, 32'h0, 0);
        add_entry(OP_WRITE, ADDR_FB, fb_word(1'b0, 1'b0, 6'd37, 5'd19), 0, 0);
        add_entry(OP_READ, ADDR_FB, 0, 32'h1, 0);
        // Timers
        add_entry(OP_WRITE, ADDR_DELAY, 32'h3, 0, 0);
        add_entry(OP_IDLE, 0, 0, 0, 6 * TICK_DIV);
        add_entry(OP_READ, ADDR_DELAY, 0, 32'h0, 0);
        add_entry(OP_WRITE, ADDR_SOUND, 32'hF0, 0, 0);
        add_entry(OP_RANGE, ADDR_SOUND, 0, 32'hF0, 0);
        // Four reads queued behind a stalled R channel
        add_entry(OP_ISSUE, ADDR_V_BASE + 18'd2, 0, 0, 0);
        add_entry(OP_ISSUE, ADDR_V_BASE + 18'd7, 0, 0, 0);
        add_entry(OP_ISSUE, ADDR_V_BASE + 18'd11, 0, 0, 0);
        add_entry(OP_ISSUE, ADDR_V_BASE + 18'd14, 0, 0, 0);
        add_entry(OP_COLLECT, ADDR_V_BASE + 18'd2, 0, {24'h0, v_vals[2]}, 0);
        add_entry(OP_COLLECT, ADDR_V_BASE + 18'd7, 0, {24'h0, v_vals[7]}, 0);
        add_entry(OP_COLLECT, ADDR_V_BASE + 18'd11, 0, {24'h0, v_vals[11]}, 0);
        add_entry(OP_COLLECT, ADDR_V_BASE + 18'd14, 0, {24'h0, v_vals[14]}, 0);
    endtask

    initial begin
        int errs_before;
        cpu_fbreset = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'hF;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        seed    = 32'hf0aa_0edb;
        build_tests();
        cycle_limit = n_entries * 40 + wait_sum + 100;
        repeat (3) @(posedge clk);
        #1;
        cpu_fbreset = 1'b0;
        for (int i = 0; i < n_entries; i++) begin
            errs_before = error_count;
            apply_entry(tests[i]);
            if (error_count == errs_before) begin
                pass_count = pass_count + 1;
                $display("test %0d %s at 0x%0h ok", i, op_name(tests[i].op), tests[i].addr);
            end else begin
                fail_count = fail_count + 1;
                $display("test %0d %s at 0x%0h failed", i, op_name(tests[i].op), tests[i].addr);
            end
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 n_entries, pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hw/chip8_pkg.sv
hw/axil_host_port.sv
hw/host_fifo.sv
hw/chip8_reg_block.sv
hw/chip8_timers.sv
hw/chip8_host_top.sv
verif/tb_chip8_host.sv
